// File: Makefile
VERILATOR ?= verilator
TOP       := tb_dbg_subsys
FILELIST  := compile.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the simulator output is scanned for the pass line, no log is kept
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: axil_ram.sv
`include "dbg_macros.svh"

module axil_ram (
    input  logic                clk,
    input  logic                rst,

    input  sba_pkg::axil_req_t  axil_req,
    output sba_pkg::axil_rsp_t  axil_rsp
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    logic [`DM_DATA_W-1:0] mem [0:`MEM_WORDS-1];

    logic                  b_valid;
    logic [1:0]            b_resp;
    logic                  r_valid;
    logic [`DM_DATA_W-1:0] r_data;
    logic [1:0]            r_resp;

    logic [`SB_ADDR_W-1:0] w_off;
    logic [`SB_ADDR_W-1:0] r_off;
    logic                  w_hit;
    logic                  r_hit;
    logic [IDX_W-1:0]      w_idx;
    logic [IDX_W-1:0]      r_idx;
    logic                  wr_fire;
    logic                  rd_fire;

    // below the base wraps to a large offset and fails the check too
    assign w_off = axil_req.aw_addr - `MEM_BASE;
    assign r_off = axil_req.ar_addr - `MEM_BASE;
    assign w_hit = (w_off >> 2) < `MEM_WORDS;
    assign r_hit = (r_off >> 2) < `MEM_WORDS;
    assign w_idx = w_off[IDX_W+1:2];
    assign r_idx = r_off[IDX_W+1:2];

    // write takes aw and w in one go, only with no response pending
    assign wr_fire = axil_req.aw_valid && axil_req.w_valid && !b_valid;
    assign rd_fire = axil_req.ar_valid && !r_valid;

    always_comb begin
        axil_rsp          = '0;
        axil_rsp.aw_ready = wr_fire;
        axil_rsp.w_ready  = wr_fire;
        axil_rsp.b_valid  = b_valid;
        axil_rsp.b_resp   = b_resp;
        axil_rsp.ar_ready = !r_valid;
        axil_rsp.r_valid  = r_valid;
        axil_rsp.r_data   = r_data;
        axil_rsp.r_resp   = r_resp;
    end

    always_ff @(posedge clk) begin
        if (wr_fire && w_hit) begin
            for (int i = 0; i < `DM_DATA_W/8; i++) begin
                if (axil_req.w_strb[i]) begin
                    mem[w_idx][i*8 +: 8] <= axil_req.w_data[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid <= 1'b0;
            b_resp  <= 2'b00;
            r_valid <= 1'b0;
            r_data  <= '0;
            r_resp  <= 2'b00;
        end else begin
            if (axil_req.b_ready) begin
                b_valid <= 1'b0;
            end
            if (wr_fire) begin
                b_valid <= 1'b1;
                // SLVERR outside the RAM window
                b_resp  <= w_hit ? 2'b00 : 2'b10;
            end

            if (axil_req.r_ready) begin
                r_valid <= 1'b0;
            end
            if (rd_fire) begin
                r_valid <= 1'b1;
                r_data  <= r_hit ? mem[r_idx] : '0;
                r_resp  <= r_hit ? 2'b00 : 2'b10;
            end
        end
    end

endmodule

// File: compile.f
+incdir+.
dmi_pkg.sv
sba_pkg.sv
dm_regs.sv
sba_master.sv
axil_ram.sv
dbg_subsys.sv
tb_dbg_subsys.sv

// File: dbg_macros.svh
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// DMI address width, as reported by the DTM in dtmcs.abits
`define DM_ABITS 7

// DMI data and system bus data width
`define DM_DATA_W 32

// system bus address width
`define SB_ADDR_W 32

// RAM behind the system bus, depth in 32-bit words
`define MEM_WORDS 1024
`define MEM_BASE 32'h0100_0000

// debug spec 0.13 reports version 2 in dmstatus
`define DM_VERSION 2

`endif

// File: dbg_subsys.sv
module dbg_subsys (
    input  logic                clk,
    input  logic                rst,

    input  logic                dmi_req_valid,
    input  dmi_pkg::dmi_req_t   dmi_req,
    output logic                dmi_req_ready,
    output logic                dmi_rsp_valid,
    output dmi_pkg::dmi_rsp_t   dmi_rsp,
    input  logic                dmi_rsp_ready,

    output logic                halt_req,
    output logic                resume_req,
    input  logic                hart_halted,
    input  logic                hart_resume_ack
);

    logic                sb_cmd_valid;
    sba_pkg::sb_cmd_t    sb_cmd;
    logic                sb_cmd_ready;
    logic                sb_done_valid;
    sba_pkg::sb_done_t   sb_done;

    sba_pkg::axil_req_t  axil_req;
    sba_pkg::axil_rsp_t  axil_rsp;

    // DMI registers, hart control and bus command source
    dm_regs u_dm_regs (
        .clk             (clk),
        .rst             (rst),
        .dmi_req_valid   (dmi_req_valid),
        .dmi_req         (dmi_req),
        .dmi_req_ready   (dmi_req_ready),
        .dmi_rsp_valid   (dmi_rsp_valid),
        .dmi_rsp         (dmi_rsp),
        .dmi_rsp_ready   (dmi_rsp_ready),
        .halt_req        (halt_req),
        .resume_req      (resume_req),
        .hart_halted     (hart_halted),
        .hart_resume_ack (hart_resume_ack),
        .sb_cmd_valid    (sb_cmd_valid),
        .sb_cmd          (sb_cmd),
        .sb_cmd_ready    (sb_cmd_ready),
        .sb_done_valid   (sb_done_valid),
        .sb_done         (sb_done)
    );

    sba_master u_sba_master (
        .clk           (clk),
        .rst           (rst),
        .sb_cmd_valid  (sb_cmd_valid),
        .sb_cmd        (sb_cmd),
        .sb_cmd_ready  (sb_cmd_ready),
        .sb_done_valid (sb_done_valid),
        .sb_done       (sb_done),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp)
    );

    axil_ram u_axil_ram (
        .clk      (clk),
        .rst      (rst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

endmodule

// File: dm_regs.sv
`include "dbg_macros.svh"

module dm_regs (
    input  logic                clk,
    input  logic                rst,

    input  logic                dmi_req_valid,
    input  dmi_pkg::dmi_req_t   dmi_req,
    output logic                dmi_req_ready,
    output logic                dmi_rsp_valid,
    output dmi_pkg::dmi_rsp_t   dmi_rsp,
    input  logic                dmi_rsp_ready,

    output logic                halt_req,
    output logic                resume_req,
    input  logic                hart_halted,
    input  logic                hart_resume_ack,

    output logic                sb_cmd_valid,
    output sba_pkg::sb_cmd_t    sb_cmd,
    input  logic                sb_cmd_ready,
    input  logic                sb_done_valid,
    input  sba_pkg::sb_done_t   sb_done
);

    dmi_pkg::dm_ctrl_t     ctrl;
    logic                  resume_ack;
    logic                  sbbusy;
    logic                  sbreadonaddr;
    sba_pkg::sb_err_e      sberror;
    logic [`SB_ADDR_W-1:0] sbaddress0;
    logic [`DM_DATA_W-1:0] sbdata0;
    logic                  sb_read;

    dmi_pkg::dm_reg_e      req_reg;
    logic                  req_fire;
    logic                  is_access;
    logic                  blocked;
    logic                  wr_ok;
    logic [`DM_DATA_W-1:0] dmstatus;
    logic [`DM_DATA_W-1:0] sbcs;
    logic [`DM_DATA_W-1:0] rd_data;

    // one request in flight, next one waits until the response is taken
    assign dmi_req_ready = !dmi_rsp_valid;
    assign req_fire      = dmi_req_valid && dmi_req_ready;
    assign req_reg       = dmi_pkg::dm_reg_e'(dmi_req.addr);

    assign is_access = (dmi_req.op == dmi_pkg::dmi_read) || (dmi_req.op == dmi_pkg::dmi_write);
    assign blocked   = sbbusy && is_access &&
                       ((req_reg == dmi_pkg::reg_sbaddress0) || (req_reg == dmi_pkg::reg_sbdata0));
    assign wr_ok     = req_fire && (dmi_req.op == dmi_pkg::dmi_write) && !blocked;

    assign halt_req   = ctrl.haltreq;
    assign resume_req = ctrl.resumereq;

    // bus command goes out in the same cycle as the triggering write
    assign sb_cmd_valid = wr_ok && ((req_reg == dmi_pkg::reg_sbdata0) ||
                          ((req_reg == dmi_pkg::reg_sbaddress0) && sbreadonaddr));

    always_comb begin
        sb_cmd.write = (req_reg == dmi_pkg::reg_sbdata0);
        sb_cmd.addr  = sb_cmd.write ? sbaddress0 : `SB_ADDR_W'(dmi_req.data);
        sb_cmd.data  = dmi_req.data;
    end

    always_comb begin
        dmstatus        = '0;
        dmstatus[17]    = resume_ack;
        dmstatus[16]    = resume_ack;
        // single hart, so all and any agree
        dmstatus[9]     = hart_halted;
        dmstatus[8]     = hart_halted;
        dmstatus[3:0]   = 4'(`DM_VERSION);

        sbcs            = '0;
        sbcs[21]        = sbbusy;
        sbcs[20]        = sbreadonaddr;
        sbcs[19:17]     = 3'd2;
        sbcs[14:12]     = sberror;
        sbcs[11:5]      = 7'd32;
    end

    always_comb begin
        case (req_reg)
            dmi_pkg::reg_dmcontrol:  rd_data = {ctrl.haltreq, ctrl.resumereq, 29'd0, ctrl.dmactive};
            dmi_pkg::reg_dmstatus:   rd_data = dmstatus;
            dmi_pkg::reg_sbcs:       rd_data = sbcs;
            dmi_pkg::reg_sbaddress0: rd_data = `DM_DATA_W'(sbaddress0);
            dmi_pkg::reg_sbdata0:    rd_data = sbdata0;
            default:                 rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dmi_rsp_valid <= 1'b0;
            dmi_rsp       <= '0;
            ctrl          <= '0;
            resume_ack    <= 1'b0;
            sbbusy        <= 1'b0;
            sbreadonaddr  <= 1'b0;
            sberror       <= sba_pkg::sb_err_none;
            sbaddress0    <= '0;
            sbdata0       <= '0;
            sb_read       <= 1'b0;
        end else begin
            if (hart_resume_ack) begin
                resume_ack <= 1'b1;
            end
            if (dmi_rsp_valid && dmi_rsp_ready) begin
                dmi_rsp_valid <= 1'b0;
            end

            if (req_fire) begin
                dmi_rsp_valid <= 1'b1;
                dmi_rsp.data  <= '0;
                if (blocked) begin
                    dmi_rsp.resp <= dmi_pkg::dmi_busy;
                end else begin
                    dmi_rsp.resp <= dmi_pkg::dmi_ok;
                    if (dmi_req.op == dmi_pkg::dmi_read) begin
                        dmi_rsp.data <= rd_data;
                    end
                end
            end

            if (wr_ok) begin
                case (req_reg)
                    dmi_pkg::reg_dmcontrol: begin
                        ctrl.haltreq   <= dmi_req.data[31];
                        ctrl.resumereq <= dmi_req.data[30];
                        ctrl.dmactive  <= dmi_req.data[0];
                        // new resume request, forget the old ack
                        if (dmi_req.data[30]) begin
                            resume_ack <= 1'b0;
                        end
                    end
                    dmi_pkg::reg_sbcs: begin
                        sbreadonaddr <= dmi_req.data[20];
                        if (|dmi_req.data[14:12]) begin
                            sberror <= sba_pkg::sb_err_none;
                        end
                    end
                    dmi_pkg::reg_sbaddress0: sbaddress0 <= `SB_ADDR_W'(dmi_req.data);
                    dmi_pkg::reg_sbdata0:    sbdata0 <= dmi_req.data;
                    default: ;
                endcase
            end

            if (sb_cmd_valid && sb_cmd_ready) begin
                sbbusy  <= 1'b1;
                sb_read <= !sb_cmd.write;
            end

            // completion wins over a same-cycle sberror clear
            if (sb_done_valid) begin
                sbbusy <= 1'b0;
                if (sb_done.err != sba_pkg::sb_err_none) begin
                    sberror <= sb_done.err;
                end else if (sb_read) begin
                    sbdata0 <= sb_done.rdata;
                end
            end
        end
    end

endmodule

// File: dmi_pkg.sv
`include "dbg_macros.svh"

package dmi_pkg;

    // op field of a DMI request
    typedef enum logic [1:0] {
        dmi_nop   = 2'd0,
        dmi_read  = 2'd1,
        dmi_write = 2'd2
    } dmi_op_e;

    // op field of a DMI response
    typedef enum logic [1:0] {
        dmi_ok     = 2'd0,
        dmi_failed = 2'd2,
        dmi_busy   = 2'd3
    } dmi_resp_e;

    // implemented debug module registers
    typedef enum logic [`DM_ABITS-1:0] {
        reg_dmcontrol  = 'h10,
        reg_dmstatus   = 'h11,
        reg_sbcs       = 'h38,
        reg_sbaddress0 = 'h39,
        reg_sbdata0    = 'h3C
    } dm_reg_e;

    // same field order as the DTM dmi shift register
    typedef struct packed {
        logic [`DM_ABITS-1:0]  addr;
        logic [`DM_DATA_W-1:0] data;
        dmi_op_e               op;
    } dmi_req_t;

    typedef struct packed {
        logic [`DM_DATA_W-1:0] data;
        dmi_resp_e             resp;
    } dmi_rsp_t;

    // dmcontrol bits kept for the single hart
    typedef struct packed {
        logic haltreq;
        logic resumereq;
        logic dmactive;
    } dm_ctrl_t;

endpackage

// File: sba_master.sv
`include "dbg_macros.svh"

module sba_master (
    input  logic                clk,
    input  logic                rst,

    input  logic                sb_cmd_valid,
    input  sba_pkg::sb_cmd_t    sb_cmd,
    output logic                sb_cmd_ready,
    output logic                sb_done_valid,
    output sba_pkg::sb_done_t   sb_done,

    output sba_pkg::axil_req_t  axil_req,
    input  sba_pkg::axil_rsp_t  axil_rsp
);

    sba_pkg::sba_state_e state;
    sba_pkg::sb_cmd_t    cmd_q;
    logic                aw_done;
    logic                w_done;

    logic                aw_fire;
    logic                w_fire;
    logic                ar_fire;
    logic                b_fire;
    logic                r_fire;
    logic                aw_ok;
    logic                w_ok;
    logic [1:0]          resp;

    // only one command at a time
    assign sb_cmd_ready = (state == sba_pkg::sba_idle);

    always_comb begin
        axil_req          = '0;
        axil_req.aw_addr  = cmd_q.addr;
        axil_req.w_data   = cmd_q.data;
        axil_req.w_strb   = '1;
        axil_req.ar_addr  = cmd_q.addr;

        if (state == sba_pkg::sba_addr) begin
            // aw and w go up together, each drops once taken
            axil_req.aw_valid = cmd_q.write && !aw_done;
            axil_req.w_valid  = cmd_q.write && !w_done;
            axil_req.ar_valid = !cmd_q.write;
        end

        if (state == sba_pkg::sba_resp) begin
            axil_req.b_ready = cmd_q.write;
            axil_req.r_ready = !cmd_q.write;
        end
    end

    assign aw_fire = axil_req.aw_valid && axil_rsp.aw_ready;
    assign w_fire  = axil_req.w_valid && axil_rsp.w_ready;
    assign ar_fire = axil_req.ar_valid && axil_rsp.ar_ready;
    assign b_fire  = axil_req.b_ready && axil_rsp.b_valid;
    assign r_fire  = axil_req.r_ready && axil_rsp.r_valid;

    assign aw_ok = aw_done || aw_fire;
    assign w_ok  = w_done || w_fire;
    assign resp  = cmd_q.write ? axil_rsp.b_resp : axil_rsp.r_resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= sba_pkg::sba_idle;
            cmd_q         <= '0;
            aw_done       <= 1'b0;
            w_done        <= 1'b0;
            sb_done_valid <= 1'b0;
            sb_done       <= '0;
        end else begin
            sb_done_valid <= 1'b0;

            case (state)
                sba_pkg::sba_idle: begin
                    if (sb_cmd_valid) begin
                        cmd_q   <= sb_cmd;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= sba_pkg::sba_addr;
                    end
                end
                sba_pkg::sba_addr: begin
                    if (cmd_q.write) begin
                        aw_done <= aw_ok;
                        w_done  <= w_ok;
                        if (aw_ok && w_ok) begin
                            state <= sba_pkg::sba_resp;
                        end
                    end else if (ar_fire) begin
                        state <= sba_pkg::sba_resp;
                    end
                end
                sba_pkg::sba_resp: begin
                    if (b_fire || r_fire) begin
                        sb_done_valid <= 1'b1;
                        sb_done.rdata <= cmd_q.write ? '0 : axil_rsp.r_data;
                        // any error response maps to a bad address
                        if (resp != 2'b00) begin
                            sb_done.err <= sba_pkg::sb_err_badaddr;
                        end else begin
                            sb_done.err <= sba_pkg::sb_err_none;
                        end
                        state <= sba_pkg::sba_idle;
                    end
                end
                default: state <= sba_pkg::sba_idle;
            endcase
        end
    end

endmodule

// File: sba_pkg.sv
`include "dbg_macros.svh"

package sba_pkg;

    // sberror field of sbcs, only the codes this path can raise
    typedef enum logic [2:0] {
        sb_err_none    = 3'd0,
        sb_err_badaddr = 3'd2
    } sb_err_e;

    // one 32-bit system bus access
    typedef struct packed {
        logic                  write;
        logic [`SB_ADDR_W-1:0] addr;
        logic [`DM_DATA_W-1:0] data;
    } sb_cmd_t;

    typedef struct packed {
        logic [`DM_DATA_W-1:0] rdata;
        sb_err_e               err;
    } sb_done_t;

    // AXI4-Lite, manager side
    typedef struct packed {
        logic                    aw_valid;
        logic [`SB_ADDR_W-1:0]   aw_addr;
        logic                    w_valid;
        logic [`DM_DATA_W-1:0]   w_data;
        logic [`DM_DATA_W/8-1:0] w_strb;
        logic                    b_ready;
        logic                    ar_valid;
        logic [`SB_ADDR_W-1:0]   ar_addr;
        logic                    r_ready;
    } axil_req_t;

    // AXI4-Lite, subordinate side
    typedef struct packed {
        logic                  aw_ready;
        logic                  w_ready;
        logic                  b_valid;
        logic [1:0]            b_resp;
        logic                  ar_ready;
        logic                  r_valid;
        logic [`DM_DATA_W-1:0] r_data;
        logic [1:0]            r_resp;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        sba_idle = 2'd0,
        sba_addr = 2'd1,
        sba_resp = 2'd2
    } sba_state_e;

endpackage

// File: tb_dbg_subsys.sv
`include "dbg_macros.svh"

module tb_dbg_subsys;
    timeunit 1ns;
    timeprecision 1ps;

    // about 400 DMI accesses at under 50 cycles each
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int NUM_SB = 32;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    logic              dmi_req_valid = 1'b0;
    dmi_pkg::dmi_req_t dmi_req = '0;
    logic              dmi_req_ready;
    logic              dmi_rsp_valid;
    dmi_pkg::dmi_rsp_t dmi_rsp;
    logic              dmi_rsp_ready = 1'b0;
    logic              halt_req;
    logic              resume_req;
    logic              hart_halted = 1'b0;
    logic              hart_resume_ack = 1'b0;

    logic [31:0]        env_seed = 32'h0b1dc42b;
    logic               bp_enable = 1'b0;
    int                 halt_cnt = 0;
    int                 cycles = 0;
    int                 rsp_errors = 0;
    int                 val_errors = 0;
    int                 accesses = 0;
    string              exp_name = "";
    dmi_pkg::dmi_resp_e exp_resp = dmi_pkg::dmi_ok;
    logic [31:0]        exp_data = '0;
    logic [31:0]        exp_mask = '0;
    logic [31:0]        ref_mem [0:`MEM_WORDS-1];
    int                 sb_idx [NUM_SB];

    dbg_subsys u_dbg_subsys (
        .clk             (clk),
        .rst             (rst),
        .dmi_req_valid   (dmi_req_valid),
        .dmi_req         (dmi_req),
        .dmi_req_ready   (dmi_req_ready),
        .dmi_rsp_valid   (dmi_rsp_valid),
        .dmi_rsp         (dmi_rsp),
        .dmi_rsp_ready   (dmi_rsp_ready),
        .halt_req        (halt_req),
        .resume_req      (resume_req),
        .hart_halted     (hart_halted),
        .hart_resume_ack (hart_resume_ack)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] word_addr(input int idx);
        return `MEM_BASE + 32'(idx) * 32'd4;
    endfunction

    // dmstatus as the debug spec lays it out for one hart
    function automatic logic [31:0] dmstatus_value(input logic halted, input logic ack);
        logic [31:0] v;
        v = 32'(`DM_VERSION);
        v[9:8] = {halted, halted};
        v[17:16] = {ack, ack};
        return v;
    endfunction

    // idle sbcs with 32-bit access on a 32-bit bus
    function automatic logic [31:0] sbcs_value(input logic ron, input logic [2:0] err);
        logic [31:0] v;
        v = '0;
        v[20] = ron;
        v[19:17] = 3'd2;
        v[14:12] = err;
        v[11:5] = 7'd32;
        return v;
    endfunction

    // hart model and random back-pressure on responses
    always @(posedge clk) begin
        env_seed = lcg_step(env_seed);
        dmi_rsp_ready <= !bp_enable || (env_seed[17:16] != 2'b00);
        hart_resume_ack <= 1'b0;
        if (rst) begin
            hart_halted <= 1'b0;
            halt_cnt <= 0;
        end else if (hart_halted) begin
            if (resume_req) begin
                hart_halted <= 1'b0;
                hart_resume_ack <= 1'b1;
            end
        end else if (halt_req) begin
            if (halt_cnt == 0) begin
                halt_cnt <= 1 + int'(env_seed[26:24]);
            end else if (halt_cnt == 1) begin
                hart_halted <= 1'b1;
                halt_cnt <= 0;
            end else begin
                halt_cnt <= halt_cnt - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("accesses: %0d, response errors: %0d, value errors: %0d",
                     accesses, rsp_errors, val_errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    // every taken response against the expectation of the current access
    property rsp_matches;
        @(posedge clk) disable iff (rst)
        (dmi_rsp_valid && dmi_rsp_ready) |->
            ((dmi_rsp.resp == exp_resp) && ((dmi_rsp.data & exp_mask) == exp_data));
    endproperty

    rsp_check: assert property (rsp_matches)
    else begin
        rsp_errors++;
        $display("FAIL %s: expected resp %0d data %08h, actual resp %0d data %08h",
                 exp_name, exp_resp, exp_data, dmi_rsp.resp, dmi_rsp.data & exp_mask);
    end

    // answer one cycle after acceptance and hold it with requests blocked until taken
    property rsp_handshake;
        @(posedge clk) disable iff (rst)
        ((dmi_req_valid && dmi_req_ready) || (dmi_rsp_valid && !dmi_rsp_ready)) |=>
            (dmi_rsp_valid && !dmi_req_ready);
    endproperty

    handshake_check: assert property (rsp_handshake)
    else begin
        rsp_errors++;
        $display("DMI response was late, dropped before it was taken, or let a request in (%s)",
                 exp_name);
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else begin
            val_errors++;
            $display("FAIL %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    // starts on a rising edge and returns on the edge that takes the response
    task automatic dmi_access(input string name, input dmi_pkg::dmi_op_e op,
                              input logic [`DM_ABITS-1:0] addr, input logic [31:0] wdata,
                              input dmi_pkg::dmi_resp_e resp, input logic [31:0] data,
                              input logic [31:0] mask, output logic [31:0] rdata);
        dmi_req_valid <= 1'b1;
        dmi_req.addr <= addr;
        dmi_req.data <= wdata;
        dmi_req.op <= op;
        @(negedge clk);
        while (!dmi_req_ready) begin
            @(negedge clk);
        end
        exp_name = name;
        exp_resp = resp;
        exp_data = data & mask;
        exp_mask = mask;
        accesses++;
        @(posedge clk);
        dmi_req_valid <= 1'b0;
        @(negedge clk);
        while (!(dmi_rsp_valid && dmi_rsp_ready)) begin
            @(negedge clk);
        end
        rdata = dmi_rsp.data;
        @(posedge clk);
    endtask

    task automatic write_reg(input string name, input logic [`DM_ABITS-1:0] addr,
                             input logic [31:0] wdata);
        logic [31:0] unused;
        dmi_access(name, dmi_pkg::dmi_write, addr, wdata, dmi_pkg::dmi_ok, '0, '0, unused);
    endtask

    task automatic read_expect(input string name, input logic [`DM_ABITS-1:0] addr,
                               input logic [31:0] data);
        logic [31:0] unused;
        dmi_access(name, dmi_pkg::dmi_read, addr, '0, dmi_pkg::dmi_ok, data, '1, unused);
    endtask

    task automatic read_poll(input string name, input logic [`DM_ABITS-1:0] addr,
                             output logic [31:0] rdata);
        dmi_access(name, dmi_pkg::dmi_read, addr, '0, dmi_pkg::dmi_ok, '0, '0, rdata);
    endtask

    task automatic wait_sb_idle();
        logic [31:0] sbcs;
        sbcs = 32'h0020_0000;
        while (sbcs[21]) begin
            read_poll("sbbusy poll", dmi_pkg::reg_sbcs, sbcs);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] seed;
        int          idx;

        seed = 32'h0b1dc42b;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        bp_enable <= 1'b1;
        @(posedge clk);

        write_reg("dmactive", dmi_pkg::reg_dmcontrol, 32'h0000_0001);
        read_expect("dmcontrol readback", dmi_pkg::reg_dmcontrol, 32'h0000_0001);
        read_expect("dmstatus version", dmi_pkg::reg_dmstatus, dmstatus_value(1'b0, 1'b0));
        read_expect("sbcs reset", dmi_pkg::reg_sbcs, sbcs_value(1'b0, 3'd0));
        read_expect("unknown address", 7'h05, 32'h0);
        dmi_access("nop", dmi_pkg::dmi_nop, 7'h00, '1, dmi_pkg::dmi_ok, '0, '0, rdata);

        // ack stays sticky from the previous round
        for (int i = 0; i < 3; i++) begin
            write_reg("haltreq", dmi_pkg::reg_dmcontrol, 32'h8000_0001);
            check_value("halt_req level", 32'd1, 32'(halt_req));
            rdata = '0;
            while (!rdata[9]) begin
                read_poll("allhalted poll", dmi_pkg::reg_dmstatus, rdata);
            end
            read_expect("dmstatus halted", dmi_pkg::reg_dmstatus, dmstatus_value(1'b1, i > 0));
            write_reg("resumereq", dmi_pkg::reg_dmcontrol, 32'h4000_0001);
            check_value("resume_req level", 32'd1, 32'(resume_req));
            rdata = '0;
            while (!rdata[17]) begin
                read_poll("resumeack poll", dmi_pkg::reg_dmstatus, rdata);
            end
            read_expect("dmstatus resumed", dmi_pkg::reg_dmstatus, dmstatus_value(1'b0, 1'b1));
            write_reg("dmcontrol idle", dmi_pkg::reg_dmcontrol, 32'h0000_0001);
        end

        // sbaddress0 writes also start reads here but the data write follows
        write_reg("sbreadonaddr on", dmi_pkg::reg_sbcs, 32'h0010_0000);
        for (int i = 0; i < NUM_SB; i++) begin
            seed = lcg_step(seed);
            idx = int'(seed[31:8] % `MEM_WORDS);
            seed = lcg_step(seed);
            sb_idx[i] = idx;
            ref_mem[idx] = seed;
            write_reg("sbaddress0", dmi_pkg::reg_sbaddress0, word_addr(idx));
            wait_sb_idle();
            write_reg("sbdata0 write", dmi_pkg::reg_sbdata0, seed);
            wait_sb_idle();
        end
        for (int i = 0; i < NUM_SB; i++) begin
            write_reg("sbaddress0 read", dmi_pkg::reg_sbaddress0, word_addr(sb_idx[i]));
            wait_sb_idle();
            read_expect("sbdata0 readback", dmi_pkg::reg_sbdata0, ref_mem[sb_idx[i]]);
        end
        read_expect("sbcs after bus", dmi_pkg::reg_sbcs, sbcs_value(1'b1, 3'd0));

        // without back-pressure the next access lands while the bus is busy
        bp_enable <= 1'b0;
        repeat (2) @(posedge clk);
        idx = sb_idx[0];
        write_reg("sbaddress0 busy", dmi_pkg::reg_sbaddress0, word_addr(idx));
        dmi_access("sbdata0 read busy", dmi_pkg::dmi_read, dmi_pkg::reg_sbdata0, '0,
                   dmi_pkg::dmi_busy, '0, '0, rdata);
        wait_sb_idle();
        read_expect("sbdata0 after busy read", dmi_pkg::reg_sbdata0, ref_mem[idx]);
        write_reg("sbaddress0 busy write", dmi_pkg::reg_sbaddress0, word_addr(idx));
        dmi_access("sbdata0 write busy", dmi_pkg::dmi_write, dmi_pkg::reg_sbdata0,
                   32'h1234_5678, dmi_pkg::dmi_busy, '0, '0, rdata);
        wait_sb_idle();
        read_expect("sbdata0 after busy write", dmi_pkg::reg_sbdata0, ref_mem[idx]);
        ref_mem[idx] = ~ref_mem[idx];
        write_reg("sbdata0 bus write", dmi_pkg::reg_sbdata0, ref_mem[idx]);
        dmi_access("sbdata0 read after write", dmi_pkg::dmi_read, dmi_pkg::reg_sbdata0, '0,
                   dmi_pkg::dmi_busy, '0, '0, rdata);
        wait_sb_idle();
        read_expect("sbdata0 after write", dmi_pkg::reg_sbdata0, ref_mem[idx]);
        write_reg("sbaddress0 reread", dmi_pkg::reg_sbaddress0, word_addr(idx));
        wait_sb_idle();
        read_expect("sbdata0 bus readback", dmi_pkg::reg_sbdata0, ref_mem[idx]);
        bp_enable <= 1'b1;

        // the address below the base aliases the top word if the range check fails
        write_reg("sbreadonaddr off", dmi_pkg::reg_sbcs, 32'h0);
        write_reg("sbaddress0 top", dmi_pkg::reg_sbaddress0, word_addr(`MEM_WORDS - 1));
        write_reg("sbdata0 top", dmi_pkg::reg_sbdata0, 32'h5a5a_a5a5);
        wait_sb_idle();
        ref_mem[`MEM_WORDS-1] = 32'h5a5a_a5a5;
        write_reg("sbaddress0 below base", dmi_pkg::reg_sbaddress0, `MEM_BASE - 32'd4);
        write_reg("sbdata0 bad address", dmi_pkg::reg_sbdata0, 32'hdead_beef);
        wait_sb_idle();
        read_expect("sberror badaddr", dmi_pkg::reg_sbcs, sbcs_value(1'b0, 3'd2));
        write_reg("sbreadonaddr on", dmi_pkg::reg_sbcs, 32'h0010_0000);
        read_expect("sberror kept", dmi_pkg::reg_sbcs, sbcs_value(1'b1, 3'd2));
        write_reg("sbaddress0 top read", dmi_pkg::reg_sbaddress0, word_addr(`MEM_WORDS - 1));
        wait_sb_idle();
        read_expect("top word unchanged", dmi_pkg::reg_sbdata0, ref_mem[`MEM_WORDS-1]);
        write_reg("sberror clear", dmi_pkg::reg_sbcs, 32'h0010_7000);
        read_expect("sberror cleared", dmi_pkg::reg_sbcs, sbcs_value(1'b1, 3'd0));

        $display("accesses: %0d, response errors: %0d, value errors: %0d",
                 accesses, rsp_errors, val_errors);
        if (rsp_errors == 0 && val_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
